/* list.f */
verilog/pcie_tlp_pkg.sv
verilog/core_regs_pkg.sv
verilog/cq_request_decoder.sv
verilog/core_register_file.sv
verilog/cc_completion_builder.sv
verilog/fpga_core.sv
testbench/tb_fpga_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_fpga_core -f list.f -o tb_fpga_core \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_fpga_core 2>&1 | tee sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: no pass line in sim.log"; exit 1; }
echo "PASS"

/* testbench/fpga_core_cases.txt */
// kind tag bar_id address dword_count wdata exp_data exp_status exp_led, all hex
// kind 0 is a memory read, 1 a memory write, any other code an unsupported type
0 01 0 00000000 001 00000000 c0de0a11 0 00
0 02 0 0000000c 001 00000000 00000000 0 00
1 03 0 00000004 001 a5a55a5a 00000000 0 00
0 04 0 00000004 001 00000000 a5a55a5a 0 00
1 05 0 00000000 001 12345678 00000000 0 00
0 06 0 00000000 001 00000000 c0de0a11 0 00
1 07 0 00000008 001 0000c33c 00000000 0 3c
0 08 0 00000008 001 00000000 0000003c 0 3c
0 09 0 0000000c 001 00000000 00000003 0 3c
0 0a 1 00000004 001 00000000 00000000 1 3c
0 0b 0 01000000 001 00000000 00000000 1 3c
0 0c 0 00000004 002 00000000 00000000 1 3c
7 0d 0 00000004 001 00000000 00000000 1 3c
1 0e 2 00000004 001 deadbeef 00000000 0 3c
1 0f 0 00fffff4 001 00000081 00000000 0 3c
0 10 0 00fffff4 001 00000000 00000081 0 3c
1 11 0 02000008 001 000000ff 00000000 0 3c
1 12 0 00000008 003 000000ff 00000000 0 3c
0 13 0 00000008 001 00000000 0000003c 0 3c
1 14 0 0000000c 001 00000099 00000000 0 3c
1 15 0 00000008 001 000001e7 00000000 0 e7
0 16 0 0000000c 001 00000000 00000006 0 e7
0 17 0 00000008 001 00000000 000000e7 0 e7
0 18 0 00000004 001 00000000 00000081 0 e7
0 19 0 00000000 001 00000000 c0de0a11 0 e7

/* testbench/tb_fpga_core.sv */
// testbench for fpga_core, replays the request cases file on CQ and checks CC, led and error pulses
`default_nettype none
`timescale 1ns/100ps

module tb_fpga_core;

    localparam int          BAR0_APERTURE = 24;     // matches the DUT default
    localparam int          MAX_CASES     = 64;
    localparam logic [2:0]  STATUS_UR     = 3'h1;   // unsupported request
    localparam logic [32:0] APERTURE_END  = 33'd1 << BAR0_APERTURE;

    logic        clk;
    logic        rst_n;
    logic [63:0] s_axis_cq_tdata;
    logic        s_axis_cq_tvalid;
    logic        s_axis_cq_tready;
    logic        s_axis_cq_tlast;
    logic [63:0] m_axis_cc_tdata;
    logic        m_axis_cc_tvalid;
    logic        m_axis_cc_tready;
    logic        m_axis_cc_tlast;
    logic [7:0]  led;
    logic        status_error_uncor;

    // cases as read from the data file
    logic [3:0]  case_kind   [MAX_CASES];
    logic [7:0]  case_tag    [MAX_CASES];
    logic [2:0]  case_bar    [MAX_CASES];
    logic [31:0] case_addr   [MAX_CASES];
    logic [10:0] case_dw     [MAX_CASES];
    logic [31:0] case_wdata  [MAX_CASES];
    logic [31:0] case_data   [MAX_CASES];
    logic [2:0]  case_status [MAX_CASES];
    logic [7:0]  case_led    [MAX_CASES];
    int          num_cases;

    // expected completions, oldest first
    logic [7:0]  exp_tag_q    [$];
    logic [31:0] exp_data_q   [$];
    logic [2:0]  exp_status_q [$];
    logic [7:0]  exp_led_q    [$];

    int          err_pulses      = 0;
    int          exp_err_pulses  = 0;
    int          cycle_count     = 0;
    int          cycle_limit     = 0;   // 0 until the cases are loaded

    fpga_core fpga_core_inst (
        .clk(clk),
        .rst_n(rst_n),
        .s_axis_cq_tdata(s_axis_cq_tdata),
        .s_axis_cq_tvalid(s_axis_cq_tvalid),
        .s_axis_cq_tready(s_axis_cq_tready),
        .s_axis_cq_tlast(s_axis_cq_tlast),
        .m_axis_cc_tdata(m_axis_cc_tdata),
        .m_axis_cc_tvalid(m_axis_cc_tvalid),
        .m_axis_cc_tready(m_axis_cc_tready),
        .m_axis_cc_tlast(m_axis_cc_tlast),
        .led(led),
        .status_error_uncor(status_error_uncor)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ***********************************************************************
    // reporting helpers
    // ***********************************************************************

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // ***********************************************************************
    // case file and request driving
    // ***********************************************************************

    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        logic [3:0]  kind;
        logic [7:0]  tag;
        logic [2:0]  bar;
        logic [31:0] addr;
        logic [10:0] dw;
        logic [31:0] wdata;
        logic [31:0] edata;
        logic [2:0]  estatus;
        logic [7:0]  eled;
        fd = $fopen("testbench/fpga_core_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the case file testbench/fpga_core_cases.txt");
            stop_on_failure();
        end
        num_cases = 0;
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                             kind, tag, bar, addr, dw, wdata, edata, estatus, eled);
            if (fields == 9 && num_cases < MAX_CASES) begin   // comment lines give 0
                case_kind[num_cases]   = kind;
                case_tag[num_cases]    = tag;
                case_bar[num_cases]    = bar;
                case_addr[num_cases]   = addr;
                case_dw[num_cases]     = dw;
                case_wdata[num_cases]  = wdata;
                case_data[num_cases]   = edata;
                case_status[num_cases] = estatus;
                case_led[num_cases]    = eled;
                num_cases++;
            end
        end
        $fclose(fd);
        assert (num_cases > 0) else begin
            $display("The case file holds no usable request lines");
            stop_on_failure();
        end
    endtask

    function automatic logic write_rejected(input int i);
        return (case_bar[i] != 3'd0) || ({1'b0, case_addr[i]} >= APERTURE_END) ||
               (case_dw[i] != 11'd1);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds the beat until tready is seen, returns just after the transfer edge
    task automatic send_beat(input logic [63:0] data, input logic last);
        logic accepted;
        s_axis_cq_tdata  = data;
        s_axis_cq_tvalid = 1'b1;
        s_axis_cq_tlast  = last;
        accepted         = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = s_axis_cq_tready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_for_drain();
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_case(input int i);
        logic [63:0] desc;
        // reserved, tag, bar_id, type, dword_count, address from msb down
        desc = {6'd0, case_tag[i], case_bar[i], case_kind[i], case_dw[i], case_addr[i]};
        if (case_kind[i] == 4'h1) begin
            wait_for_drain();                   // keeps led stable under pending reads
            if (write_rejected(i)) begin
                exp_err_pulses++;
            end
            send_beat(desc, 1'b0);
            send_beat({32'd0, case_wdata[i]}, 1'b1);
        end else begin
            exp_tag_q.push_back(case_tag[i]);
            exp_data_q.push_back(case_data[i]);
            exp_status_q.push_back(case_status[i]);
            exp_led_q.push_back(case_led[i]);
            if (case_status[i] == STATUS_UR) begin
                exp_err_pulses++;
            end
            send_beat(desc, 1'b1);
        end
        s_axis_cq_tvalid = 1'b0;
        s_axis_cq_tlast  = 1'b0;
        s_axis_cq_tdata  = 64'd0;
    endtask

    // ***********************************************************************
    // monitors
    // ***********************************************************************

    task automatic check_completion();
        logic [7:0]  exp_tag;
        logic [31:0] exp_data;
        logic [2:0]  exp_status;
        logic [7:0]  exp_led;
        assert (exp_tag_q.size() != 0) else begin
            $display("A completion arrived while no read was outstanding");
            stop_on_failure();
        end
        exp_tag    = exp_tag_q.pop_front();
        exp_data   = exp_data_q.pop_front();
        exp_status = exp_status_q.pop_front();
        exp_led    = exp_led_q.pop_front();
        check_equal("m_axis_cc_tdata[39:32]", 32'(m_axis_cc_tdata[39:32]), 32'(exp_tag));
        check_equal("m_axis_cc_tdata[31:0]", m_axis_cc_tdata[31:0], exp_data);
        check_equal("m_axis_cc_tdata[42:40]", 32'(m_axis_cc_tdata[42:40]), 32'(exp_status));
        check_equal("m_axis_cc_tdata[55:43]", 32'(m_axis_cc_tdata[55:43]), 32'd4);
        check_equal("m_axis_cc_tlast", 32'(m_axis_cc_tlast), 32'd1);
        check_equal("led", 32'(led), 32'(exp_led));
    endtask

    // inputs only move just after the rising edge, so the falling edge is quiet
    always @(negedge clk) begin
        if (rst_n) begin
            if (status_error_uncor) begin
                err_pulses++;
            end
            if (m_axis_cc_tvalid && m_axis_cc_tready) begin
                check_completion();
            end
        end
    end

    initial begin
        m_axis_cc_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            m_axis_cc_tready = ($urandom % 3) != 0;  // low about a third of the time
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run timed out after %0d cycles", cycle_count);
            stop_on_failure();
        end
    end

    // ***********************************************************************
    // main sequence
    // ***********************************************************************

    initial begin
        int idx;
        void'($urandom(32'h4572a20c));
        rst_n            = 1'b0;
        s_axis_cq_tdata  = 64'd0;
        s_axis_cq_tvalid = 1'b0;
        s_axis_cq_tlast  = 1'b0;

        load_cases();
        cycle_limit = num_cases * 40 + 200;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal("s_axis_cq_tready", 32'(s_axis_cq_tready), 32'd0);
        check_equal("m_axis_cc_tvalid", 32'(m_axis_cc_tvalid), 32'd0);
        check_equal("status_error_uncor", 32'(status_error_uncor), 32'd0);
        check_equal("led", 32'(led), 32'd0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (idx = 0; idx < num_cases; idx++) begin
            idle_cycles($urandom % 4);
            run_case(idx);
        end

        wait_for_drain();
        idle_cycles(4);                         // room for the last error pulse
        @(negedge clk);
        assert (!m_axis_cc_tvalid) else begin
            $display("A completion is still pending after the last read finished");
            stop_on_failure();
        end
        if (err_pulses == exp_err_pulses) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Error: status_error_uncor pulse count is %h, expected %h",
                     err_pulses, exp_err_pulses);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

/* verilog/cc_completion_builder.sv */
// two-entry response FIFO that formats the oldest response as a single CC completion beat
`default_nettype none
`timescale 1ns/100ps

module cc_completion_builder (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       rsp_valid,
    input  wire  [7:0]                rsp_tag,
    input  wire  [31:0]               rsp_data,
    input  wire pcie_tlp_pkg::cpl_status_t rsp_status,
    output logic                      rsp_ready,

    output logic [63:0]               m_axis_cc_tdata,
    output logic                      m_axis_cc_tvalid,
    output logic                      m_axis_cc_tlast,
    input  wire                       m_axis_cc_tready
);
    import pcie_tlp_pkg::*;

    logic [7:0]  tag_mem    [2];
    logic [31:0] data_mem   [2];
    cpl_status_t status_mem [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  count;             // 0, 1 or 2 entries
    logic        push;
    logic        pop;

    assign rsp_ready        = count != 2'd2;
    assign m_axis_cc_tvalid = count != 2'd0;
    assign m_axis_cc_tlast  = m_axis_cc_tvalid;     // every completion is one beat
    assign push             = rsp_valid && rsp_ready;
    assign pop              = m_axis_cc_tvalid && m_axis_cc_tready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr]    <= rsp_tag;
            data_mem[wr_ptr]   <= rsp_data;
            status_mem[wr_ptr] <= rsp_status;
        end
    end

    // ***********************************************************************
    // CC beat packing, head of the FIFO
    // ***********************************************************************

    always_comb begin
        m_axis_cc_tdata = 64'd0;
        m_axis_cc_tdata[CC_DATA_LSB +: 32]  = data_mem[rd_ptr];
        m_axis_cc_tdata[CC_TAG_LSB +: 8]    = tag_mem[rd_ptr];
        m_axis_cc_tdata[CC_STATUS_LSB +: 3] = status_mem[rd_ptr];
        m_axis_cc_tdata[CC_BYTE_COUNT_LSB +: CC_BYTE_COUNT_WIDTH] = CPL_BYTE_COUNT;
    end

endmodule

`default_nettype wire

/* verilog/core_register_file.sv */
// BAR0 register block, serves decoded requests, returns read responses and drives the LEDs
`default_nettype none
`timescale 1ns/100ps

module core_register_file (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       req_valid,
    input  wire                       req_write,
    input  wire core_regs_pkg::reg_index_t req_index,
    input  wire  [31:0]               req_wdata,
    input  wire  [7:0]                req_tag,
    input  wire                       req_bad,
    output logic                      req_ready,

    output logic                      rsp_valid,
    output logic [7:0]                rsp_tag,
    output logic [31:0]               rsp_data,
    output pcie_tlp_pkg::cpl_status_t rsp_status,
    input  wire                       rsp_ready,

    output logic [7:0]                led
);
    import pcie_tlp_pkg::*;
    import core_regs_pkg::*;

    logic [31:0] scratch_reg;
    logic [31:0] write_count;
    logic [31:0] rd_data [REG_COUNT];
    logic        req_fire;

    // stall only while a response is stuck
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_comb begin
        rd_data[REG_ID]          = CORE_ID;
        rd_data[REG_SCRATCH]     = scratch_reg;
        rd_data[REG_LED]         = {24'd0, led};
        rd_data[REG_WRITE_COUNT] = write_count;
    end

    // ***********************************************************************
    // register writes
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch_reg <= 32'd0;
            led         <= 8'd0;
            write_count <= 32'd0;
        end else if (req_fire && req_write && !req_bad) begin
            write_count <= write_count + 32'd1;    // read-only targets count too
            case (req_index)
                REG_SCRATCH: scratch_reg <= req_wdata;
                REG_LED:     led         <= req_wdata[7:0];
                default:     ;
            endcase
        end
    end

    // ***********************************************************************
    // read responses
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !req_write) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !req_write) begin
            rsp_tag    <= req_tag;
            rsp_data   <= req_bad ? 32'd0 : rd_data[req_index];
            rsp_status <= req_bad ? unsupported_request : success;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_regs_pkg.sv */
// register map of the BAR0 core registers, imported by the register file and the decoder
`default_nettype none

package core_regs_pkg;

    // dword index, taken from address bits 3:2
    typedef enum logic [1:0] {
        REG_ID          = 2'd0,     // read-only identification
        REG_SCRATCH     = 2'd1,     // read/write
        REG_LED         = 2'd2,     // read/write, low 8 bits drive the LEDs
        REG_WRITE_COUNT = 2'd3      // read-only, accepted writes
    } reg_index_t;

    localparam int REG_COUNT = 4;

    // value returned by REG_ID
    localparam logic [31:0] CORE_ID = 32'hc0de_0a11;

endpackage

`default_nettype wire

/* verilog/cq_request_decoder.sv */
// takes CQ descriptor beats, validates each request and holds it for the register file
`default_nettype none
`timescale 1ns/100ps

module cq_request_decoder #(
    parameter int BAR0_APERTURE = 24
) (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire  [63:0]               s_axis_cq_tdata,
    input  wire                       s_axis_cq_tvalid,
    input  wire                       s_axis_cq_tlast,
    output logic                      s_axis_cq_tready,

    output logic                      req_valid,
    output logic                      req_write,
    output core_regs_pkg::reg_index_t req_index,
    output logic [31:0]               req_wdata,
    output logic [7:0]                req_tag,
    output logic                      req_bad,
    input  wire                       req_ready,

    output logic                      status_error_uncor
);
    import pcie_tlp_pkg::*;
    import core_regs_pkg::*;

    localparam logic [1:0] ST_HEADER  = 2'd0;
    localparam logic [1:0] ST_WDATA   = 2'd1;
    localparam logic [1:0] ST_DISCARD = 2'd2;

    logic [1:0] state;
    logic       drop_err;           // rejected write still waiting for tlast
    cq_beat_u   beat;
    cq_desc_t   desc;
    logic       beat_fire;
    logic       hit_ok;
    logic       is_read;
    logic       is_write;
    logic       load_req;
    logic       req_valid_next;
    logic       err_now;

    assign beat      = s_axis_cq_tdata;
    assign desc      = beat.desc;
    assign beat_fire = s_axis_cq_tvalid && s_axis_cq_tready;
    assign is_read   = desc.req_type == mem_read;
    assign is_write  = desc.req_type == mem_write;

    // BAR0, inside the aperture, exactly one dword
    assign hit_ok = (desc.bar_id == 3'd0) &&
                    ((desc.address >> BAR0_APERTURE) == 32'd0) &&
                    (desc.dword_count == 11'd1);

    // ***********************************************************************
    // request hand-off and error detection
    // ***********************************************************************

    always_comb begin
        load_req = 1'b0;
        err_now  = 1'b0;
        if (beat_fire) begin
            case (state)
                ST_HEADER: begin
                    if (is_write) begin
                        err_now = s_axis_cq_tlast;      // bad or missing its data beat
                    end else begin
                        load_req = 1'b1;                // unknown types answer as reads
                        err_now  = !(is_read && hit_ok);
                    end
                end
                ST_WDATA: load_req = 1'b1;
                default:  err_now = drop_err && s_axis_cq_tlast;
            endcase
        end
    end

    assign req_valid_next = load_req || (req_valid && !req_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state              <= ST_HEADER;
            drop_err           <= 1'b0;
            req_valid          <= 1'b0;
            s_axis_cq_tready   <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            req_valid          <= req_valid_next;
            s_axis_cq_tready   <= !req_valid_next;  // one held request at a time
            status_error_uncor <= err_now;
            if (beat_fire) begin
                case (state)
                    ST_HEADER: begin
                        drop_err <= is_write && !hit_ok;
                        if (s_axis_cq_tlast) begin
                            state <= ST_HEADER;
                        end else if (is_write && hit_ok) begin
                            state <= ST_WDATA;
                        end else begin
                            state <= ST_DISCARD;
                        end
                    end
                    ST_WDATA: begin
                        drop_err <= 1'b0;
                        state    <= s_axis_cq_tlast ? ST_HEADER : ST_DISCARD;
                    end
                    default: begin
                        if (s_axis_cq_tlast) begin
                            state <= ST_HEADER;
                        end
                    end
                endcase
            end
        end
    end

    // request payload, only written while no request is held
    always_ff @(posedge clk) begin
        if (beat_fire && state == ST_HEADER) begin
            req_tag   <= desc.tag;
            req_index <= reg_index_t'(desc.address[3:2]);   // upper bits alias
            req_write <= is_write;
            req_bad   <= !(is_read && hit_ok);
        end
        if (beat_fire && state == ST_WDATA) begin
            req_wdata <= beat.wr.data;
            req_bad   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/fpga_core.sv */
// completer core top level, wires the CQ decoder, BAR0 registers and CC completion path
`default_nettype none
`timescale 1ns/100ps

module fpga_core #(
    parameter int BAR0_APERTURE = 24
) (
    input  wire         clk,
    input  wire         rst_n,

    input  wire  [63:0] s_axis_cq_tdata,
    input  wire         s_axis_cq_tvalid,
    output logic        s_axis_cq_tready,
    input  wire         s_axis_cq_tlast,

    output logic [63:0] m_axis_cc_tdata,
    output logic        m_axis_cc_tvalid,
    input  wire         m_axis_cc_tready,
    output logic        m_axis_cc_tlast,

    output logic [7:0]  led,
    output logic        status_error_uncor
);
    import pcie_tlp_pkg::*;
    import core_regs_pkg::*;

    // decoder to register file
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    reg_index_t  req_index;
    logic [31:0] req_wdata;
    logic [7:0]  req_tag;
    logic        req_bad;

    // register file to completion builder
    logic        rsp_valid;
    logic        rsp_ready;
    logic [7:0]  rsp_tag;
    logic [31:0] rsp_data;
    cpl_status_t rsp_status;

    cq_request_decoder #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) cq_request_decoder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .s_axis_cq_tdata(s_axis_cq_tdata),
        .s_axis_cq_tvalid(s_axis_cq_tvalid),
        .s_axis_cq_tlast(s_axis_cq_tlast),
        .s_axis_cq_tready(s_axis_cq_tready),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_index(req_index),
        .req_wdata(req_wdata),
        .req_tag(req_tag),
        .req_bad(req_bad),
        .req_ready(req_ready),
        .status_error_uncor(status_error_uncor)
    );

    core_register_file core_register_file_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_index(req_index),
        .req_wdata(req_wdata),
        .req_tag(req_tag),
        .req_bad(req_bad),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_tag(rsp_tag),
        .rsp_data(rsp_data),
        .rsp_status(rsp_status),
        .rsp_ready(rsp_ready),
        .led(led)
    );

    cc_completion_builder cc_completion_builder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rsp_valid(rsp_valid),
        .rsp_tag(rsp_tag),
        .rsp_data(rsp_data),
        .rsp_status(rsp_status),
        .rsp_ready(rsp_ready),
        .m_axis_cc_tdata(m_axis_cc_tdata),
        .m_axis_cc_tvalid(m_axis_cc_tvalid),
        .m_axis_cc_tlast(m_axis_cc_tlast),
        .m_axis_cc_tready(m_axis_cc_tready)
    );

endmodule

`default_nettype wire

/* verilog/pcie_tlp_pkg.sv */
// request, completion and stream beat definitions shared by the CQ and CC side modules
`default_nettype none

package pcie_tlp_pkg;

    // ***********************************************************************
    // request and completion codes
    // ***********************************************************************

    typedef enum logic [3:0] {
        mem_read  = 4'h0,
        mem_write = 4'h1
    } req_type_t;                       // any other code is unsupported

    typedef enum logic [2:0] {
        success             = 3'b000,
        unsupported_request = 3'b001
    } cpl_status_t;

    // ***********************************************************************
    // completer request (CQ) beat
    // ***********************************************************************

    // first field is the most significant, so the address sits in 31:0
    typedef struct packed {
        logic [5:0]  reserved;
        logic [7:0]  tag;
        logic [2:0]  bar_id;
        req_type_t   req_type;
        logic [10:0] dword_count;
        logic [31:0] address;
    } cq_desc_t;

    // header beat reads as a descriptor, a write's second beat as payload
    typedef union packed {
        cq_desc_t desc;
        struct packed {
            logic [31:0] upper;         // unused on data beats
            logic [31:0] data;
        } wr;
    } cq_beat_u;

    // ***********************************************************************
    // completer completion (CC) beat layout
    // ***********************************************************************

    localparam int CC_DATA_LSB         = 0;     // 31:0
    localparam int CC_TAG_LSB          = 32;    // 39:32
    localparam int CC_STATUS_LSB       = 40;    // 42:40
    localparam int CC_BYTE_COUNT_LSB   = 43;    // 55:43
    localparam int CC_BYTE_COUNT_WIDTH = 13;

    // single dword completions only
    localparam logic [CC_BYTE_COUNT_WIDTH-1:0] CPL_BYTE_COUNT = 13'd4;

endpackage

`default_nettype wire
